// File: alu_bitslice.sv
`timescale 1ns/1ps
`default_nettype none

// one bit of the ALU
// a full adder for the arithmetic ops plus the five bitwise ops, muxed by sel
module alu_bitslice (
	input  logic     a_i, // operand A bit
	input  logic     b_i, // operand B bit, not yet inverted
	input  logic     carry_i, // carry from the slice below, or sub at bit 0
	alu_ctrl_if.slice ctrl,
	output logic     result_o, // selected result bit, before SLT conditioning
	output logic     carry_o // adder carry into the slice above
);
	import alu_pkg::*;

	logic b_eff; // B after optional inversion for subtract
	logic a_xor_b; // half-sum, shared by the adder and the XOR op
	logic sum_bit;
	logic gen; // carry generate
	logic prop_carry; // carry propagated through this bit

	// ---------------------------------------------------------------------
	// arithmetic
	// ---------------------------------------------------------------------
	assign b_eff      = b_i ^ ctrl.sub; // subtract feeds ~B into the adder
	assign a_xor_b    = a_i ^ b_eff;
	assign sum_bit    = a_xor_b ^ carry_i;
	assign gen        = a_i & b_eff;
	assign prop_carry = a_xor_b & carry_i;
	assign carry_o    = gen | prop_carry; // ripples regardless of the selected op

	// ---------------------------------------------------------------------
	// result select
	// ---------------------------------------------------------------------
	// the bitwise ops use the raw B bit, the inversion only matters to the adder
	always_comb begin
		case (ctrl.sel)
			SEL_SUM:  result_o = sum_bit; // ADD, SUB and SLT
			SEL_XOR:  result_o = a_i ^ b_i;
			SEL_AND:  result_o = a_i & b_i;
			SEL_NAND: result_o = ~(a_i & b_i);
			SEL_NOR:  result_o = ~(a_i | b_i);
			SEL_OR:   result_o = a_i | b_i;
			default:  result_o = 1'b0; // selects 6 and 7 are never decoded
		endcase
	end

endmodule

`default_nettype wire

// File: alu_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// command lookup table
// ---------------------------------------------------------------------------
// one copy for the whole ALU, the slices and the result stage read its lines
// through the control interface

module alu_ctrl_decode (
	input  alu_pkg::alu_op_e command_i, // command sampled with the operands
	alu_ctrl_if.decode       ctrl
);
	import alu_pkg::*;

	always_comb begin
		// defaults describe a plain logic operation
		ctrl.sel        = SEL_SUM;
		ctrl.sub        = 1'b0;
		ctrl.slt_mode   = 1'b0;
		ctrl.arith_mode = 1'b0;
		case (command_i)
			OP_ADD: begin
				ctrl.sel        = SEL_SUM;
				ctrl.arith_mode = 1'b1;
			end
			OP_SUB: begin
				ctrl.sel        = SEL_SUM;
				ctrl.sub        = 1'b1; // A + ~B + 1
				ctrl.arith_mode = 1'b1;
			end
			OP_SLT: begin
				ctrl.sel      = SEL_SUM; // sign of A - B decides the answer
				ctrl.sub      = 1'b1;
				ctrl.slt_mode = 1'b1; // flags stay quiet, not arithmetic mode
			end
			OP_XOR:  ctrl.sel = SEL_XOR;
			OP_AND:  ctrl.sel = SEL_AND;
			OP_NAND: ctrl.sel = SEL_NAND;
			OP_NOR:  ctrl.sel = SEL_NOR;
			OP_OR:   ctrl.sel = SEL_OR;
			default: ctrl.sel = SEL_SUM; // unreachable with a 3-bit enum
		endcase
	end

endmodule

`default_nettype wire

// File: alu_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded control lines shared by the decoder, every slice and the result stage
interface alu_ctrl_if;
	import alu_pkg::*;

	alu_sel_e sel; // result select inside each slice
	logic     sub; // invert B and carry a one into bit 0
	logic     slt_mode; // only SLT squashes the result down to one bit
	logic     arith_mode; // only ADD and SUB report carryout and overflow

	// the decoder owns all four lines
	modport decode (output sel, output sub, output slt_mode, output arith_mode);

	// a slice only needs to know what to pick and whether to subtract
	modport slice (input sel, input sub);

	// the output stage conditions the flags and the SLT result
	modport result (input slt_mode, input arith_mode);

endinterface

`default_nettype wire

// File: alu_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// shared widths, encodings and types for the bit-sliced ALU
// ---------------------------------------------------------------------------

package alu_pkg;

	localparam int unsigned ALU_WIDTH = 32; // operand and result width, one word
	localparam int unsigned ALU_MSB   = ALU_WIDTH - 1; // sign bit position
	localparam int unsigned ALU_OP_W  = 3; // command field is three bits wide
	localparam int unsigned ALU_SEL_W = 3; // slice result select is three bits wide

	// command encoding as seen on command_i
	typedef enum logic [ALU_OP_W-1:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_XOR  = 3'd2,
		OP_SLT  = 3'd3, // signed set-less-than, only bit 0 can be set
		OP_AND  = 3'd4,
		OP_NAND = 3'd5,
		OP_NOR  = 3'd6,
		OP_OR   = 3'd7
	} alu_op_e;

	// which per-bit result each slice forwards
	// ADD, SUB and SLT all share the adder output
	typedef enum logic [ALU_SEL_W-1:0] {
		SEL_SUM  = 3'd0,
		SEL_XOR  = 3'd1,
		SEL_AND  = 3'd2,
		SEL_NAND = 3'd3,
		SEL_NOR  = 3'd4,
		SEL_OR   = 3'd5
	} alu_sel_e;

	typedef logic [ALU_WIDTH-1:0] alu_word_t; // one data word

endpackage

`default_nettype wire

// File: alu_properties.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// assertions on the registered outputs of the result stage
// ---------------------------------------------------------------------------

module alu_properties (
	input logic               clk_i,
	input logic               rst_n_i,
	input logic               arith_mode_i, // decoded line, high for ADD and SUB
	input alu_pkg::alu_word_t result_i,
	input logic               carryout_i,
	input logic               zero_i,
	input logic               overflow_i
);
	import alu_pkg::*;

	logic past_valid = 1'b0; // outputs are unknown until the first edge

	always @(posedge clk_i) begin
		past_valid <= 1'b1;
	end

	// logic ops and SLT never raise the arithmetic flags
	a_flags_quiet: assert property (@(posedge clk_i)
		!arith_mode_i |=> (!carryout_i && !overflow_i))
		else $error("carryout or overflow set after a non-arithmetic operation");

	// zero follows the registered result exactly
	a_zero_matches: assert property (@(posedge clk_i)
		past_valid |-> (zero_i == (result_i == '0)))
		else $error("zero flag disagrees with the result");

	a_reset_values: assert property (@(posedge clk_i)
		!rst_n_i |=> (result_i == '0 && zero_i && !carryout_i && !overflow_i))
		else $error("outputs not at their reset values after a reset edge");

endmodule

// one copy inside the result stage of the DUT
bind alu_result_stage alu_properties u_props (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.arith_mode_i (ctrl.arith_mode),
	.result_i     (result_o),
	.carryout_i   (carryout_o),
	.zero_i       (zero_o),
	.overflow_i   (overflow_o)
);

`default_nettype wire

// File: alu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// output conditioning and registers
// ---------------------------------------------------------------------------
// takes the raw slice outputs and the two carries around the MSB, builds the
// SLT answer and the flags, and registers everything on the rising edge

module alu_result_stage (
	input  logic               clk_i,
	input  logic               rst_n_i, // synchronous, active low
	input  alu_pkg::alu_word_t raw_result_i, // straight out of the slices
	input  logic               carry_msb_in_i, // carry into the MSB slice
	input  logic               carry_out_i, // carry out of the MSB slice
	alu_ctrl_if.result         ctrl,
	output alu_pkg::alu_word_t result_o,
	output logic               carryout_o,
	output logic               zero_o,
	output logic               overflow_o
);
	import alu_pkg::*;

	logic      overflow_raw; // signed overflow of whatever the adder did
	logic      neg_overflow; // A negative, B positive and A - B wrapped positive
	logic      msb_negative; // result sign when there was no overflow
	logic      less_than; // A < B as signed numbers, valid when sub was set
	alu_word_t result_next; // conditioned result, D input of the register
	logic      carryout_next;
	logic      overflow_next;
	logic      zero_next;

	// ---------------------------------------------------------------------
	// overflow and the signed comparison
	// ---------------------------------------------------------------------
	assign overflow_raw = carry_msb_in_i ^ carry_out_i; // carries around the MSB disagree

	// carry out without carry in means the true difference is negative
	assign neg_overflow = carry_out_i & ~carry_msb_in_i;
	assign msb_negative = ~overflow_raw & raw_result_i[ALU_MSB];
	assign less_than    = neg_overflow | msb_negative;

	always_comb begin
		if (ctrl.slt_mode) begin
			result_next = '0; // only bit 0 carries the comparison
			result_next[0] = less_than;
		end else begin
			result_next = raw_result_i;
		end
	end

	// flags are meaningful only for ADD and SUB
	assign carryout_next = carry_out_i & ctrl.arith_mode;
	assign overflow_next = overflow_raw & ctrl.arith_mode;
	assign zero_next     = ~|result_next; // taken after SLT conditioning

	// ---------------------------------------------------------------------
	// output registers
	// ---------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			result_o   <= '0;
			carryout_o <= 1'b0;
			overflow_o <= 1'b0;
			zero_o     <= 1'b1; // consistent with the cleared result
		end else begin
			result_o   <= result_next;
			carryout_o <= carryout_next;
			overflow_o <= overflow_next;
			zero_o     <= zero_next;
		end
	end

endmodule

`default_nettype wire

// File: alu_top.sv
`timescale 1ns/1ps
`default_nettype none

// 32-bit ALU top level
// operands and command are taken on every rising edge, results one edge later
module alu_top (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  alu_pkg::alu_word_t operand_a_i,
	input  alu_pkg::alu_word_t operand_b_i,
	input  alu_pkg::alu_op_e   command_i,
	output alu_pkg::alu_word_t result_o,
	output logic               carryout_o,
	output logic               zero_o, // high when result_o is all zeros
	output logic               overflow_o
);
	import alu_pkg::*;

	alu_ctrl_if ctrl (); // decoded lines for the slices and the output stage

	logic [ALU_WIDTH:0] carry; // carry[0] is the chain input, carry[ALU_WIDTH] the carryout
	alu_word_t          raw_result; // slice outputs before SLT conditioning

	alu_ctrl_decode u_decode (
		.command_i (command_i),
		.ctrl      (ctrl.decode)
	);

	// ---------------------------------------------------------------------
	// slice array and ripple carry chain
	// ---------------------------------------------------------------------
	assign carry[0] = ctrl.sub; // the +1 of two's complement subtract

	for (genvar i = 0; i < ALU_WIDTH; i++) begin : g_slice
		alu_bitslice u_slice (
			.a_i      (operand_a_i[i]),
			.b_i      (operand_b_i[i]),
			.carry_i  (carry[i]),
			.ctrl     (ctrl.slice),
			.result_o (raw_result[i]),
			.carry_o  (carry[i+1])
		);
	end

	// the stage needs both carries around the MSB for overflow and SLT
	alu_result_stage u_result (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.raw_result_i   (raw_result),
		.carry_msb_in_i (carry[ALU_WIDTH-1]),
		.carry_out_i    (carry[ALU_WIDTH]),
		.ctrl           (ctrl.result),
		.result_o       (result_o),
		.carryout_o     (carryout_o),
		.zero_o         (zero_o),
		.overflow_o     (overflow_o)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator, verdict comes from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_alu

# the simulator status is not trusted on its own, the log decides
./obj_dir/Vtb_alu | tee sim.log || true

if grep -qx "TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: sources.f
alu_pkg.sv
alu_ctrl_if.sv
alu_ctrl_decode.sv
alu_bitslice.sv
alu_result_stage.sv
alu_top.sv
alu_properties.sv
tb_alu_checker.sv
tb_alu.sv

// File: tb_alu.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// testbench top for the bit-sliced ALU
// ---------------------------------------------------------------------------
// directed corner cases come first, then random traffic over every opcode
// the checker instance does all of the comparing against its own model

module tb_alu;
	import alu_pkg::*;

	localparam int unsigned SEED           = 32'h72e2eb24;
	localparam int unsigned RESET_CYCLES   = 8;
	localparam int unsigned RANDOM_VECTORS = 2000;
	// reset, 17 directed vectors, a short reset pulse, the random run and the drain
	// take about 2035 cycles, so this leaves a comfortable margin
	localparam int unsigned MAX_CYCLES     = 2500;

	logic        clk;
	logic        rst_n;
	alu_word_t   operand_a;
	alu_word_t   operand_b;
	alu_op_e     command;
	alu_word_t   result;
	logic        carryout;
	logic        zero;
	logic        overflow;
	int unsigned check_count; // field comparisons done by the checker
	int unsigned error_count; // mismatches seen by the checker
	int unsigned cycle_count = 0;

	alu_top u_dut (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.command_i   (command),
		.result_o    (result),
		.carryout_o  (carryout),
		.zero_o      (zero),
		.overflow_o  (overflow)
	);

	tb_alu_checker u_check (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.operand_a_i   (operand_a),
		.operand_b_i   (operand_b),
		.command_i     (command),
		.result_i      (result),
		.carryout_i    (carryout),
		.zero_i        (zero),
		.overflow_i    (overflow),
		.check_count_o (check_count),
		.error_count_o (error_count)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	// ---------------------------------------------------------------------
	// stimulus helpers, everything changes on the falling edge
	// ---------------------------------------------------------------------
	task automatic drive_vector(input alu_word_t a, input alu_word_t b, input alu_op_e op);
		@(negedge clk);
		operand_a = a;
		operand_b = b;
		command   = op;
	endtask

	task automatic pulse_reset(input int unsigned cycles);
		@(negedge clk);
		rst_n = 1'b0; // the operands keep their last values while reset is low
		repeat (cycles) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// watchdog so that a stuck run still ends with a verdict
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("ERROR the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		alu_word_t a;
		alu_word_t b;
		alu_op_e   op;
		void'($urandom(SEED)); // one seed for the whole run
		rst_n     = 1'b0;
		operand_a = '0;
		operand_b = '0;
		command   = OP_ADD;
		repeat (RESET_CYCLES) @(negedge clk); // eight rising edges with reset low
		rst_n = 1'b1;

		// corner cases around the sign bit and the carry chain
		drive_vector(32'h7fff_ffff, 32'h0000_0001, OP_ADD); // positive overflow
		drive_vector(32'h8000_0000, 32'h8000_0000, OP_ADD); // negative overflow, carry, zero
		drive_vector(32'hffff_ffff, 32'h0000_0001, OP_ADD); // carry out with a zero result
		drive_vector(32'h0000_0000, 32'h0000_0000, OP_ADD);
		drive_vector(32'h1234_5678, 32'h1234_5678, OP_SUB); // equal operands give zero
		drive_vector(32'h8000_0000, 32'h0000_0001, OP_SUB); // wraps to positive
		drive_vector(32'h7fff_ffff, 32'hffff_ffff, OP_SUB); // wraps to negative
		drive_vector(32'h0000_0000, 32'h0000_0001, OP_SUB); // borrow, no carry out
		drive_vector(32'h8000_0000, 32'h0000_0001, OP_SLT); // less than although A - B overflows
		drive_vector(32'h7fff_ffff, 32'hffff_ffff, OP_SLT); // not less, again with overflow
		drive_vector(32'h0000_0005, 32'h0000_0005, OP_SLT);
		drive_vector(32'hffff_ffff, 32'h0000_0000, OP_SLT); // minus one is below zero
		drive_vector(32'haaaa_5555, 32'haaaa_5555, OP_XOR);
		drive_vector(32'hf0f0_f0f0, 32'h0f0f_0f0f, OP_AND);
		drive_vector(32'hffff_ffff, 32'hffff_ffff, OP_NAND);
		drive_vector(32'h0000_0000, 32'h0000_0000, OP_NOR); // all ones from all zeros
		drive_vector(32'h0000_0000, 32'h0000_0000, OP_OR);

		pulse_reset(2); // reset in the middle of traffic

		repeat (RANDOM_VECTORS) begin
			a  = $urandom();
			b  = $urandom();
			op = alu_op_e'(ALU_OP_W'($urandom_range(7, 0)));
			if ($urandom_range(7, 0) == 0) begin
				b = a; // equal operands now and then, so zero_o gets exercised
			end
			drive_vector(a, b, op);
		end
		repeat (3) @(posedge clk); // let the last result reach the checker

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// scoreboard for the ALU ports
// ---------------------------------------------------------------------------
// predicts each result from the inputs seen at a rising edge and compares it
// on the following falling edge, when the registered outputs are settled

module tb_alu_checker (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  alu_pkg::alu_word_t operand_a_i,
	input  alu_pkg::alu_word_t operand_b_i,
	input  alu_pkg::alu_op_e   command_i,
	input  alu_pkg::alu_word_t result_i, // DUT result_o
	input  logic               carryout_i,
	input  logic               zero_i,
	input  logic               overflow_i,
	output int unsigned        check_count_o,
	output int unsigned        error_count_o
);
	import alu_pkg::*;

	typedef struct packed {
		alu_word_t result;
		logic      carryout;
		logic      zero;
		logic      overflow;
	} model_t;

	model_t      model_q; // what the outputs must show after the last edge
	logic        model_valid_q = 1'b0; // nothing to compare before the first edge
	int unsigned checks = 0;
	int unsigned errors = 0;

	assign check_count_o = checks;
	assign error_count_o = errors;

	// ---------------------------------------------------------------------
	// reference model, written from the arithmetic rules and not the gates
	// ---------------------------------------------------------------------
	function automatic model_t predict_outcome(input alu_word_t a, input alu_word_t b,
		input alu_op_e op);
		model_t             m;
		alu_word_t          b_add; // second adder operand, B or not B
		logic               cin;
		logic [ALU_WIDTH:0] wide; // 33-bit sum, top bit is the carry out
		m     = '0;
		cin   = (op == OP_SUB);
		b_add = cin ? ~b : b;
		case (op)
			OP_ADD, OP_SUB: begin
				wide       = {1'b0, a} + {1'b0, b_add} + {{ALU_WIDTH{1'b0}}, cin};
				m.result   = wide[ALU_WIDTH-1:0];
				m.carryout = wide[ALU_WIDTH];
				// same signs in, different sign out
				m.overflow = (a[ALU_MSB] == b_add[ALU_MSB]) && (m.result[ALU_MSB] != a[ALU_MSB]);
			end
			OP_SLT:  m.result = {{(ALU_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};
			OP_XOR:  m.result = a ^ b;
			OP_AND:  m.result = a & b;
			OP_NAND: m.result = ~(a & b);
			OP_NOR:  m.result = ~(a | b);
			OP_OR:   m.result = a | b;
			default: m.result = '0;
		endcase
		m.zero = (m.result == '0); // flags other than zero stay 0 outside ADD and SUB
		return m;
	endfunction

	task automatic compare_word(input string name, input alu_word_t expected,
		input alu_word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	// one-cycle expectation pipe, in step with the DUT output registers
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			model_q.result   <= '0;
			model_q.carryout <= 1'b0;
			model_q.zero     <= 1'b1; // a cleared result reads as zero
			model_q.overflow <= 1'b0;
		end else begin
			model_q <= predict_outcome(operand_a_i, operand_b_i, command_i);
		end
		model_valid_q <= 1'b1;
	end

	always @(negedge clk_i) begin
		if (model_valid_q) begin
			compare_word("result_o", model_q.result, result_i);
			compare_bit("carryout_o", model_q.carryout, carryout_i);
			compare_bit("zero_o", model_q.zero, zero_i);
			compare_bit("overflow_o", model_q.overflow, overflow_i);
		end
	end

endmodule

`default_nettype wire
